/* flist.f */
+incdir+.
exLanePkg.sv
operandIssue.sv
laneShifter.sv
exLaneEx1.sv
laneRetire.sv
exLaneTop.sv
exLane_checker.sv
exLaneTb.sv

/* run.sh */
#!/bin/sh
# build and run the exLane testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module exLaneTb -f flist.f -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

/* exLaneTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exLane_consts.svh"

module exLaneTb;
	import exLanePkg::*;

	localparam int NBUNDLES = 60;	// per random test
	localparam int CYCLE_LIMIT = 4 * (4 * NBUNDLES + 30) + 300;

	logic clock, reset, issueValid, issueReady, halt;
	issueBundleT issueBundle;
	retireWriteT [`EX_LANES-1:0] wrPort;
	logic [1:0] faultLane;
	uCmdT faultCmd;

	integer seed = 32'ha6f2d281;
	int cycleCount = 0;
	int errCount = 0;
	int testErrs, checkCount = 0, testCount = 0;
	regValT mirror [`EX_NREGS];	// model register file
	retireWriteT [`EX_LANES-1:0] expQ [$];	// expected write sets
	int dueQ [$];	// cycle each set shows up
	logic expHalt;
	logic [1:0] expLane;
	uCmdT expCmd;
	regIdT lastRm [`EX_LANES];	// previous bundle's destinations

	exLaneTop u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > CYCLE_LIMIT) begin
			$display("timeout: no progress within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic checkVal(input logic [63:0] got, input logic [63:0] exp, input string msg);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			testErrs++;
			$display("ERR @%0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	// signed amount, modulo width, 32-bit result extended by kind
	function automatic regValT shiftModel(input regValT v, input logic [7:0] amt,
			input logic arith, input logic quad);
		int a;
		int n;
		regValT x;
		logic [31:0] lo;
		a = $signed(amt);
		n = (a < 0 ? -a : a) % (quad ? 64 : 32);
		if (quad) begin
			if (a >= 0) x = v << n;
			else if (arith) x = $signed(v) >>> n;
			else x = v >> n;
			return x;
		end
		if (a >= 0) lo = v[31:0] << n;
		else if (arith) lo = $signed(v[31:0]) >>> n;
		else lo = v[31:0] >> n;
		return arith ? {{32{lo[31]}}, lo} : {32'b0, lo};
	endfunction

	function automatic laneResultT laneModel(input laneOpT op, input logic t, input logic fl);
		laneResultT r;
		regValT rs, rt;
		logic en;
		rs = mirror[op.idRs];	// ZZR entry never written, stays zero
		rt = mirror[op.idRt];
		r = '0;
		r.idRn = op.idRm;
		r.cmd = op.uCmd;
		en = (op.uCmd[7:6] == `EX_CC_AL) || (op.uCmd[7:6] == `EX_CC_CT && t) ||
			(op.uCmd[7:6] == `EX_CC_CF && !t);
		if (en && !fl) begin
			r.valid = 1'b1;
			case (op.uCmd[5:0])
				`EX_UCMD_NOP: r.valid = 1'b0;
				`EX_UCMD_MOV_IR: case (op.uIxt[3:0])
					4'h0: r.valRn = rt;
					4'h1: r.valRn = (rs << 8) | (rt & 64'hff);
					4'h2: r.valRn = (rs << 16) | (rt & 64'hffff);
					4'h3: r.valRn = (rs << 32) | (rt & 64'hffff_ffff);
					default: r.fault = 1'b1;
				endcase
				`EX_UCMD_SHAD3: r.valRn = shiftModel(rs, rt[7:0], 1'b1, 1'b0);
				`EX_UCMD_SHLD3: r.valRn = shiftModel(rs, rt[7:0], 1'b0, 1'b0);
				`EX_UCMD_SHADQ3: r.valRn = shiftModel(rs, rt[7:0], 1'b1, 1'b1);
				`EX_UCMD_SHLDQ3: r.valRn = shiftModel(rs, rt[7:0], 1'b0, 1'b1);
				`EX_UCMD_OP_IXS: case (op.uIxt[5:0])
					`EX_IXS_NOP: r.valid = 1'b0;
					`EX_IXS_MOVT: r.valRn = {63'b0, t};
					`EX_IXS_MOVNT: r.valRn = {63'b0, !t};
					default: r.fault = 1'b1;
				endcase
				default: r.fault = 1'b1;	// unsupported here
			endcase
			if (r.fault) r.valid = 1'b0;
		end
		return r;
	endfunction

	// whole bundle as one set, operands from mirror
	task automatic applyBundle(input issueBundleT b);
		laneResultT r [`EX_LANES];
		retireWriteT [`EX_LANES-1:0] w;
		for (int l = 0; l < `EX_LANES; l++) begin
			r[l] = laneModel(b.op[l], b.srT, b.flush);
			w[l].enable = r[l].valid && (r[l].idRn != `EX_ZZR);
			w[l].id = r[l].idRn;
			w[l].value = r[l].valRn;
		end
		for (int l = 0; l < `EX_LANES; l++)
			for (int h = l + 1; h < `EX_LANES; h++)
				if (w[h].enable && w[h].id == w[l].id) w[l].enable = 1'b0;	// higher lane wins
		for (int l = `EX_LANES - 1; l >= 0; l--)
			if (r[l].fault && !expHalt) begin
				expLane = l[1:0];
				expCmd = b.op[l].uCmd;
			end
		for (int l = 0; l < `EX_LANES; l++) begin
			if (r[l].fault) expHalt = 1'b1;
			if (w[l].enable) mirror[w[l].id] = w[l].value;
		end
		expQ.push_back(w);
		dueQ.push_back(cycleCount + 2);	// accepted at next edge, visible one edge later
	endtask

	always @(negedge clock) begin : portMonitor
		retireWriteT [`EX_LANES-1:0] exp;
		exp = '0;
		if (dueQ.size() > 0 && dueQ[0] == cycleCount) begin
			exp = expQ.pop_front();
			void'(dueQ.pop_front());
		end
		if (!reset)
			for (int l = 0; l < `EX_LANES; l++) begin
				checkVal(wrPort[l].enable, exp[l].enable, $sformatf("lane %0d enable", l));
				if (exp[l].enable) begin
					checkVal(wrPort[l].id, exp[l].id, $sformatf("lane %0d id", l));
					checkVal(wrPort[l].value, exp[l].value, $sformatf("lane %0d value", l));
				end
			end
	end

	function automatic regIdT pickReg();
		int r;
		r = $random(seed) & 15;
		return (r == 15) ? `EX_ZZR : regIdT'(r & 7);	// small pool for hazards
	endfunction

	// kind 0 loads, 1 shifts, 2 predicated, 3 dependent mix
	function automatic laneOpT genOp(input int kind);
		laneOpT op;
		int sel;
		op.idRs = pickReg();
		op.idRt = pickReg();
		op.idRm = pickReg();
		sel = $random(seed) & 7;
		op.uIxt = {4'h0, 4'(sel & 3)};
		op.uCmd = {`EX_CC_AL, `EX_UCMD_MOV_IR};
		if (kind == 3) kind = sel % 3;
		if (kind == 1 && sel != 0)
			case (sel & 3)
				0: op.uCmd = {`EX_CC_AL, `EX_UCMD_SHAD3};
				1: op.uCmd = {`EX_CC_AL, `EX_UCMD_SHLD3};
				2: op.uCmd = {`EX_CC_AL, `EX_UCMD_SHADQ3};
				default: op.uCmd = {`EX_CC_AL, `EX_UCMD_SHLDQ3};
			endcase
		if ((kind == 0 && sel < 3) || kind == 2) begin
			op.uCmd = {`EX_CC_AL, `EX_UCMD_OP_IXS};
			op.uIxt = sel[0] ? {2'b0, `EX_IXS_MOVT} : {2'b0, `EX_IXS_MOVNT};
		end
		if (kind == 2) op.uCmd[7:6] = 2'($random(seed));	// any condition
		return op;
	endfunction

	function automatic issueBundleT genBundle(input int kind);
		issueBundleT b;
		for (int l = 0; l < `EX_LANES; l++) begin
			b.op[l] = genOp(kind);
			if (kind == 3 && ($random(seed) & 1))
				b.op[l].idRs = lastRm[($random(seed) & 32'h7fff) % `EX_LANES];	// RAW on last
		end
		if (kind == 3 && ($random(seed) & 1)) b.op[1].idRm = b.op[0].idRm;	// same dest
		b.srT = $random(seed);
		b.flush = (kind == 2) && (($random(seed) & 7) == 0);
		for (int l = 0; l < `EX_LANES; l++) lastRm[l] = b.op[l].idRm;
		return b;
	endfunction

	// hold the bundle until taken, give up once halted
	task automatic sendBundle(input issueBundleT b);
		logic done;
		logic held;	// valid stays up once offered
		done = 1'b0;
		held = 1'b0;
		while (!done && !halt) begin
			@(negedge clock);
			issueBundle = b;
			issueValid = held || (($random(seed) & 3) != 0);	// random gaps
			held = issueValid;
			#1;
			if (issueValid && issueReady) begin
				applyBundle(b);
				done = 1'b1;
			end
		end
	endtask

	task automatic drain();
		@(negedge clock);
		issueValid = 1'b0;
		while (dueQ.size() > 0) @(negedge clock);
		@(negedge clock);	// last write lands in the regfile
	endtask

	task automatic doReset();
		@(negedge clock);
		reset = 1'b1;
		issueValid = 1'b0;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		expQ.delete();
		dueQ.delete();
		expHalt = 1'b0;
		for (int i = 0; i < `EX_NREGS; i++) mirror[i] = '0;
	endtask

	task automatic runTest(input string name, input int kind);
		testErrs = 0;
		repeat (NBUNDLES) sendBundle(genBundle(kind));
		drain();
		for (int i = 0; i < `EX_NREGS; i++)
			checkVal(u_dut.u_issue.regFile[i], mirror[i], $sformatf("regfile r%0d", i));
		checkVal(halt, expHalt, "halt in fault-free test");	// no spurious fault
		testCount++;
		$display("test %s: %0d errors", name, testErrs);
	endtask

	initial begin : main
		issueBundleT b;
		int lane;
		reset = 1'b1;
		issueValid = 1'b0;
		issueBundle = '0;
		for (int l = 0; l < `EX_LANES; l++) lastRm[l] = '0;
		doReset();
		runTest("immediate loads", 0);
		runTest("shifts", 1);
		runTest("predication and flush", 2);
		runTest("hazards and conflicts", 3);

		// fault in a random lane, then in-flight bundles still retire
		testErrs = 0;
		doReset();
		repeat (8) sendBundle(genBundle(0));
		b = genBundle(0);
		b.flush = 1'b0;
		lane = ($random(seed) & 32'h7fff) % `EX_LANES;
		b.op[lane].uCmd = {`EX_CC_AL, 6'h20};	// memory op, unsupported
		sendBundle(b);
		repeat (4) sendBundle(genBundle(0));
		while (!halt) @(negedge clock);
		drain();
		checkVal(halt, 1'b1, "halt after fault");
		checkVal(faultLane, expLane, "faultLane");
		checkVal(faultCmd, expCmd, "faultCmd");
		repeat (3) begin
			@(negedge clock);
			issueValid = 1'b1;
			#1 checkVal(issueReady, 1'b0, "issueReady while halted");
		end
		doReset();
		@(negedge clock);
		checkVal(halt, 1'b0, "halt after reset");
		checkVal(issueReady, 1'b1, "issueReady after reset");
		testCount++;
		$display("test fault and halt: %0d errors", testErrs);

		$display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* exLane_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exLane_consts.svh"

module exLane_checker (
	input	logic									clock,
	input	logic									reset,
	input	logic									issueReady,
	input	logic									halt,
	input	exLanePkg::retireWriteT [`EX_LANES-1:0]	wrPort
);
	import exLanePkg::*;

	logic zzrHit;	// some port writes ZZR
	logic dupHit;	// two enabled ports, same id
	logic anyWrite;	// some port enabled

	always_comb begin
		zzrHit = 1'b0;
		dupHit = 1'b0;
		anyWrite = 1'b0;
		for (int l = 0; l < `EX_LANES; l++) begin
			if (wrPort[l].enable) anyWrite = 1'b1;
			if (wrPort[l].enable && wrPort[l].id == `EX_ZZR) zzrHit = 1'b1;
			for (int h = l + 1; h < `EX_LANES; h++)
				if (wrPort[l].enable && wrPort[h].enable && wrPort[l].id == wrPort[h].id)
					dupHit = 1'b1;
		end
	end

	// in-flight bundles are gone two edges after halt, nothing new issues
	haltQuiet: assert property (@(posedge clock) disable iff (reset)
		halt && $past(halt, 2) |-> !issueReady && !anyWrite)
		else $error("issue or write while halted");
	noZzrWrite: assert property (@(posedge clock) disable iff (reset) !zzrHit)
		else $error("write port targets ZZR");
	noDupWrite: assert property (@(posedge clock) disable iff (reset) !dupHit)
		else $error("two write ports share a destination");
	haltSticky: assert property (@(posedge clock) $fell(halt) |-> reset)
		else $error("halt dropped without reset");

endmodule

bind exLaneTop exLane_checker u_check (.*);

`default_nettype wire

/* exLaneTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exLane_consts.svh"

module exLaneTop (
	input	logic										clock,
	input	logic										reset,
	input	exLanePkg::issueBundleT						issueBundle,
	input	logic										issueValid,
	output	logic										issueReady,
	output	exLanePkg::retireWriteT [`EX_LANES-1:0]	wrPort,
	output	logic										halt,
	output	logic [1:0]									faultLane,
	output	exLanePkg::uCmdT							faultCmd
);
	import exLanePkg::*;

	laneSlotT [`EX_LANES-1:0]	slot;		// operand stage
	logic [`EX_LANES-1:0]		slotValid;
	laneResultT [`EX_LANES-1:0]	result;		// EX1 outputs

	operandIssue u_issue (
		.clock			(clock),
		.reset			(reset),
		.issueBundle	(issueBundle),
		.issueValid		(issueValid),
		.halt			(halt),
		.wrPort			(wrPort),	// retire writes loop back
		.issueReady		(issueReady),
		.slot			(slot),
		.slotValid		(slotValid)
	);

	// one EX1 lane per bundle slot
	for (genvar g = 0; g < `EX_LANES; g++) begin : gLane
		exLaneEx1 u_lane (
			.clock		(clock),
			.reset		(reset),
			.slot		(slot[g]),
			.slotValid	(slotValid[g]),
			.result		(result[g])
		);
	end

	laneRetire u_retire (
		.clock		(clock),
		.reset		(reset),
		.result		(result),
		.wrPort		(wrPort),
		.halt		(halt),
		.faultLane	(faultLane),
		.faultCmd	(faultCmd)
	);

endmodule

`default_nettype wire

/* laneRetire.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exLane_consts.svh"

module laneRetire (
	input	logic										clock,
	input	logic										reset,
	input	exLanePkg::laneResultT [`EX_LANES-1:0]		result,
	output	exLanePkg::retireWriteT [`EX_LANES-1:0]	wrPort,
	output	logic										halt,
	output	logic [1:0]									faultLane,
	output	exLanePkg::uCmdT							faultCmd
);
	import exLanePkg::*;

	logic [`EX_LANES-1:0]	rawEn;		// before conflict resolution
	logic					anyFault;
	logic [1:0]				firstLane;	// lowest faulting lane
	uCmdT					firstCmd;

	// write ports, higher lane wins on same Rn
	always_comb begin
		for (int l = 0; l < `EX_LANES; l++) begin
			rawEn[l] = result[l].valid && !result[l].fault &&
				(result[l].idRn != `EX_ZZR);
		end
		for (int l = 0; l < `EX_LANES; l++) begin
			wrPort[l].enable	= rawEn[l];
			wrPort[l].id		= result[l].idRn;
			wrPort[l].value		= result[l].valRn;
			for (int h = l + 1; h < `EX_LANES; h++) begin
				if (rawEn[h] && (result[h].idRn == result[l].idRn))
					wrPort[l].enable = 1'b0;	// shadowed by lane h
			end
		end
	end

	// pick lowest faulting lane, scan high to low
	always_comb begin
		anyFault	= 1'b0;
		firstLane	= 2'd0;
		firstCmd	= '0;
		for (int l = `EX_LANES - 1; l >= 0; l--) begin
			if (result[l].fault) begin
				anyFault	= 1'b1;
				firstLane	= l[1:0];
				firstCmd	= result[l].cmd;
			end
		end
	end

	// sticky halt, first fault only
	always_ff @(posedge clock) begin
		if (reset) begin
			halt		<= 1'b0;
			faultLane	<= 2'd0;
			faultCmd	<= '0;
		end else if (anyFault && !halt) begin
			halt		<= 1'b1;
			faultLane	<= firstLane;
			faultCmd	<= firstCmd;
		end
	end

endmodule

`default_nettype wire

/* exLaneEx1.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exLane_consts.svh"

module exLaneEx1 (
	input	logic						clock,
	input	logic						reset,
	input	exLanePkg::laneSlotT		slot,
	input	logic						slotValid,
	output	exLanePkg::laneResultT		result
);
	import exLanePkg::*;

	logic		opEnable;	// predicate outcome
	logic [5:0]	opCode;		// NOP when disabled
	logic		shArith;
	logic		shQuad;
	regValT		shVal;
	logic		doWrite;
	logic		doFault;
	regValT		outVal;

	// shift amount comes from the low byte of Rt
	laneShifter u_shift (
		.value	(slot.valRs),
		.amount	(slot.valRt[7:0]),
		.arith	(shArith),
		.quad	(shQuad),
		.result	(shVal)
	);

	// predicate, flush overrides everything
	always_comb begin
		case (slot.op.uCmd[7:6])
			`EX_CC_AL:	opEnable = 1'b1;
			`EX_CC_NV:	opEnable = 1'b0;
			`EX_CC_CT:	opEnable = slot.srT;
			default:	opEnable = !slot.srT;	// CF
		endcase
		if (slot.flush)
			opEnable = 1'b0;
		opCode = opEnable ? slot.op.uCmd[5:0] : `EX_UCMD_NOP;
	end

	assign shArith	= (opCode == `EX_UCMD_SHAD3) || (opCode == `EX_UCMD_SHADQ3);
	assign shQuad	= (opCode == `EX_UCMD_SHADQ3) || (opCode == `EX_UCMD_SHLDQ3);

	// decode and result select
	always_comb begin
		doWrite	= 1'b0;
		doFault	= 1'b0;
		outVal	= slot.valRt;	// LDI default

		case (opCode)
			`EX_UCMD_NOP: begin
			end

			`EX_UCMD_MOV_IR: begin
				doWrite = 1'b1;
				case (slot.op.uIxt[3:0])
					4'h0: outVal = slot.valRt;								// LDI
					4'h1: outVal = {slot.valRs[55:0], slot.valRt[7:0]};	// LDISH8
					4'h2: outVal = {slot.valRs[47:0], slot.valRt[15:0]};	// LDISH16
					4'h3: outVal = {slot.valRs[31:0], slot.valRt[31:0]};	// LDISH32
					default: begin
						doWrite	= 1'b0;
						doFault	= 1'b1;	// bad shift-in width
					end
				endcase
			end

			`EX_UCMD_SHAD3, `EX_UCMD_SHLD3,
			`EX_UCMD_SHADQ3, `EX_UCMD_SHLDQ3: begin
				outVal	= shVal;
				doWrite	= 1'b1;
			end

			`EX_UCMD_OP_IXS: begin
				case (slot.op.uIxt[5:0])
					`EX_IXS_NOP: begin
					end
					`EX_IXS_MOVT: begin
						outVal	= {63'b0, slot.srT};
						doWrite	= 1'b1;
					end
					`EX_IXS_MOVNT: begin
						outVal	= {63'b0, !slot.srT};
						doWrite	= 1'b1;
					end
					default: doFault = 1'b1;	// unknown IXS
				endcase
			end

			// mem, mul, fpu, alu3, conv... not handled in this lane
			default: doFault = 1'b1;
		endcase
	end

	// result register
	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid	<= 1'b0;
			result.fault	<= 1'b0;
		end else begin
			result.valid	<= slotValid && doWrite;
			result.fault	<= slotValid && doFault;
		end
		result.idRn		<= slot.op.idRm;
		result.valRn	<= outVal;
		result.cmd		<= slot.op.uCmd;
	end

endmodule

`default_nettype wire

/* laneShifter.sv */
`timescale 1ns/1ps
`default_nettype none

module laneShifter (
	input	exLanePkg::regValT	value,
	input	logic [7:0]			amount,	// signed, negative = right
	input	logic				arith,
	input	logic				quad,	// 64-bit mode
	output	exLanePkg::regValT	result
);
	import exLanePkg::*;

	logic			neg;
	logic [7:0]		mag;	// magnitude of amount
	logic [5:0]		cnt;	// amount modulo width
	logic [31:0]	sh32;
	regValT			sh64;

	always_comb begin
		neg	= amount[7];
		mag	= neg ? (~amount + 8'd1) : amount;
		cnt	= quad ? mag[5:0] : {1'b0, mag[4:0]};

		if (!neg) begin
			sh32 = value[31:0] << cnt[4:0];
			sh64 = value << cnt;
		end else if (arith) begin
			sh32 = $signed(value[31:0]) >>> cnt[4:0];
			sh64 = $signed(value) >>> cnt;
		end else begin
			sh32 = value[31:0] >> cnt[4:0];
			sh64 = value >> cnt;
		end

		// 32-bit result extended by shift kind
		if (quad)
			result = sh64;
		else
			result = {arith ? {32{sh32[31]}} : 32'h0, sh32};
	end

endmodule

`default_nettype wire

/* operandIssue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exLane_consts.svh"

module operandIssue (
	input	logic											clock,
	input	logic											reset,
	input	exLanePkg::issueBundleT							issueBundle,
	input	logic											issueValid,
	input	logic											halt,		// sticky fault from retire
	input	exLanePkg::retireWriteT [`EX_LANES-1:0]		wrPort,
	output	logic											issueReady,
	output	exLanePkg::laneSlotT [`EX_LANES-1:0]			slot,
	output	logic [`EX_LANES-1:0]							slotValid
);
	import exLanePkg::*;

	regValT	regFile [`EX_NREGS];	// main GPR array
	logic	readyEn;				// comes up one cycle after reset
	logic	hazard;
	logic	accept;

	// read with bypass from the retire ports, ZZR forced to zero
	function automatic regValT readReg(input regIdT id);
		regValT val;
		val = regFile[id];
		for (int w = 0; w < `EX_LANES; w++) begin
			if (wrPort[w].enable && (wrPort[w].id == id))
				val = wrPort[w].value;	// write-through
		end
		if (id == `EX_ZZR)
			val = '0;
		return val;
	endfunction

	// RAW check of the presented bundle against the operand stage
	always_comb begin
		hazard = 1'b0;
		for (int l = 0; l < `EX_LANES; l++) begin
			for (int s = 0; s < `EX_LANES; s++) begin
				if (issueValid && slotValid[s] && !slot[s].flush) begin
					if ((issueBundle.op[l].idRs != `EX_ZZR) &&
						(issueBundle.op[l].idRs == slot[s].op.idRm))
						hazard = 1'b1;	// Rs depends on slot s
					if ((issueBundle.op[l].idRt != `EX_ZZR) &&
						(issueBundle.op[l].idRt == slot[s].op.idRm))
						hazard = 1'b1;	// Rt depends on slot s
				end
			end
		end
	end

	assign issueReady	= readyEn && !halt && !hazard;
	assign accept		= issueValid && issueReady;

	always_ff @(posedge clock) begin
		if (reset)
			readyEn <= 1'b0;
		else
			readyEn <= 1'b1;
	end

	// register file, written from the retire ports
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `EX_NREGS; i++)
				regFile[i] <= '0;
		end else begin
			for (int w = 0; w < `EX_LANES; w++) begin
				if (wrPort[w].enable)
					regFile[wrPort[w].id] <= wrPort[w].value;
			end
		end
	end

	// slot valids, a stall inserts a bubble
	always_ff @(posedge clock) begin
		if (reset)
			slotValid <= '0;
		else if (accept)
			slotValid <= '1;
		else
			slotValid <= '0;
	end

	// operand capture
	always_ff @(posedge clock) begin
		if (accept) begin
			for (int l = 0; l < `EX_LANES; l++) begin
				slot[l].op		<= issueBundle.op[l];
				slot[l].valRs	<= readReg(issueBundle.op[l].idRs);
				slot[l].valRt	<= readReg(issueBundle.op[l].idRt);
				slot[l].srT		<= issueBundle.srT;		// same T for every lane
				slot[l].flush	<= issueBundle.flush;
			end
		end
	end

endmodule

`default_nettype wire

/* exLanePkg.sv */
`default_nettype none

`include "exLane_consts.svh"

package exLanePkg;

	typedef logic [5:0]		regIdT;		// register number
	typedef logic [63:0]	regValT;	// register contents
	typedef logic [7:0]		uCmdT;		// cc in [7:6], opcode in [5:0]
	typedef logic [7:0]		uIxtT;		// sub-op / immediate control

	// one micro-op as issued to a lane
	typedef struct packed {
		uCmdT	uCmd;
		uIxtT	uIxt;
		regIdT	idRs;	// source A
		regIdT	idRt;	// source B / immediate carrier
		regIdT	idRm;	// destination
	} laneOpT;

	// whole issue bundle, one op per lane
	typedef struct packed {
		laneOpT [`EX_LANES-1:0]	op;
		logic					srT;	// T bit for predication
		logic					flush;	// kill the whole bundle
	} issueBundleT;

	// operand stage contents for one lane
	typedef struct packed {
		laneOpT	op;
		regValT	valRs;
		regValT	valRt;
		logic	srT;
		logic	flush;
	} laneSlotT;

	// registered lane output
	typedef struct packed {
		logic	valid;	// wants a write
		regIdT	idRn;
		regValT	valRn;
		logic	fault;	// unsupported op seen
		uCmdT	cmd;	// uCmd carried along for fault capture
	} laneResultT;

	// one register file write port
	typedef struct packed {
		logic	enable;
		regIdT	id;
		regValT	value;
	} retireWriteT;

endpackage

`default_nettype wire

/* exLane_consts.svh */
`ifndef EXLANE_CONSTS_SVH
`define EXLANE_CONSTS_SVH

// lane count and register file size
`define EX_LANES	3		// 2..4 lanes supported
`define EX_NREGS	64
`define EX_ZZR		6'd63	// discard reg, reads as zero

// condition codes, top two bits of uCmd
`define EX_CC_AL	2'b00	// always
`define EX_CC_NV	2'b01	// never
`define EX_CC_CT	2'b10	// when T set
`define EX_CC_CF	2'b11	// when T clear

// opcodes, low six bits of uCmd
`define EX_UCMD_NOP		6'h00
`define EX_UCMD_MOV_IR	6'h06	// LDI and LDISH8/16/32
`define EX_UCMD_SHAD3	6'h0C	// 32-bit arith shift
`define EX_UCMD_SHLD3	6'h0D	// 32-bit logical shift
`define EX_UCMD_SHADQ3	6'h0E	// 64-bit arith shift
`define EX_UCMD_SHLDQ3	6'h0F	// 64-bit logical shift
`define EX_UCMD_OP_IXS	6'h30	// single-op group, sub-op in uIxt

// OP_IXS sub-ops, low six bits of uIxt
`define EX_IXS_NOP		6'h00
`define EX_IXS_MOVT		6'h01	// Rm = T
`define EX_IXS_MOVNT	6'h02	// Rm = !T

`endif
